// File: source/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32

// peripheral select field, taken at bit ADDR_W-2
`define N_SLAVES_W 1

// internal ram byte address width, 1024 words
`define MEM_ADDR_W 12

// boot region start, word index
`define BOOT_BASE_W 768

// clock cycles per uart bit
`define UART_DIV 8

// soft reset pulse length in cycles
`define SOFT_RST_CYCLES 4

`endif

// File: source/soc_bus_pkg.sv
`include "soc_macros.svh"

package soc_bus_pkg;

   // instruction fetch request, addr is word aligned
   typedef struct packed {
      logic               en;
      logic [`ADDR_W-1:0] addr;
   } ibus_req_t;

   typedef struct packed {
      logic               ready;
      logic [`DATA_W-1:0] data;
   } ibus_rsp_t;

   // nonzero wstrb means write
   typedef struct packed {
      logic               valid;
      logic [`ADDR_W-1:0] addr;
      logic [`DATA_W-1:0] wdata;
      logic [3:0]         wstrb;
   } dbus_req_t;

   typedef struct packed {
      logic               ready;
      logic [`DATA_W-1:0] rdata;
   } dbus_rsp_t;

endpackage

// File: source/soc_periph_pkg.sv
`include "soc_macros.svh"

package soc_periph_pkg;

   typedef enum logic [`N_SLAVES_W-1:0] {
      SLV_UART = 1'b0,
      SLV_RST  = 1'b1
   } slave_sel_e;

   // uart register index, address bits 4:2
   typedef enum logic [2:0] {
      UART_TXDATA  = 3'd0,
      UART_TXBUSY  = 3'd1,
      UART_RXDATA  = 3'd2,
      UART_RXVALID = 3'd3
   } uart_reg_e;

   // shared by tx and rx
   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_e;

   typedef enum logic {
      RST_RUN,
      RST_SOFT
   } rst_state_e;

endpackage

// File: source/int_mem.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module int_mem
   import soc_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      soft_rst,
   input  logic      boot,
   input  ibus_req_t ibus_req,
   output ibus_rsp_t ibus_rsp,
   input  dbus_req_t req,
   output dbus_rsp_t rsp
);

   localparam int WORD_W  = `MEM_ADDR_W - 2;
   localparam int N_WORDS = 1 << WORD_W;

   logic [`DATA_W-1:0] mem [N_WORDS];

   logic [WORD_W-1:0]  i_idx;
   logic [WORD_W-1:0]  d_idx;
   logic               i_ready;
   logic [`DATA_W-1:0] i_data;
   logic               d_ready;
   logic [`DATA_W-1:0] d_rdata;
   logic               d_acc;

   // fetches land in the boot region while booting
   assign i_idx = ibus_req.addr[`MEM_ADDR_W-1:2] | (boot ? WORD_W'(`BOOT_BASE_W) : '0);
   assign d_idx = req.addr[`MEM_ADDR_W-1:2];

   assign d_acc = req.valid && !d_ready;

   assign ibus_rsp = '{ready: i_ready, data: i_data};
   assign rsp      = '{ready: d_ready, rdata: d_rdata};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         i_ready <= 1'b0;
         d_ready <= 1'b0;
      end else if (soft_rst) begin
         i_ready <= 1'b0;
         d_ready <= 1'b0;
      end else begin
         i_ready <= ibus_req.en;
         d_ready <= d_acc;
      end
   end

   // instruction port
   always_ff @(posedge clk) begin
      if (ibus_req.en) begin
         i_data <= mem[i_idx];
      end
   end

   // data port, byte writes on the ready edge
   always_ff @(posedge clk) begin
      if (d_acc) begin
         d_rdata <= mem[d_idx];
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
               mem[d_idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

// File: source/uart.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module uart
   import soc_bus_pkg::*, soc_periph_pkg::*;
#(
   parameter int div = `UART_DIV
) (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      soft_rst,
   input  dbus_req_t req,
   output dbus_rsp_t rsp,
   output logic      txd,
   input  logic      rxd,
   output logic      rts,
   input  logic      cts
);

   localparam int CNT_W = $clog2(div + 1);

   logic               rsp_ready;
   logic [`DATA_W-1:0] rsp_rdata;
   logic               acc;
   logic               wr;
   uart_reg_e          reg_idx;
   logic               tx_load;
   logic               rx_rd;

   uart_state_e        tx_state;
   logic               tx_pend;
   logic [CNT_W-1:0]   tx_cnt;
   logic [2:0]         tx_bit;
   logic               tx_line;
   logic [7:0]         tx_byte;
   logic               tx_busy;
   logic               tx_tick;

   uart_state_e        rx_state;
   logic [1:0]         rx_sync;
   logic               rx_in;
   logic [CNT_W-1:0]   rx_cnt;
   logic [2:0]         rx_bit;
   logic [7:0]         rx_shift;
   logic [7:0]         rx_byte;
   logic               rx_valid;
   logic               rx_mid;

   assign acc     = req.valid && !rsp_ready;
   assign wr      = |req.wstrb;
   assign reg_idx = uart_reg_e'(req.addr[4:2]);
   assign tx_busy = tx_pend || (tx_state != UART_IDLE);
   assign tx_load = acc && wr && (reg_idx == UART_TXDATA) && !tx_busy;
   assign rx_rd   = acc && !wr && (reg_idx == UART_RXDATA);
   assign tx_tick = tx_cnt == CNT_W'(div - 1);
   assign rx_in   = rx_sync[1];
   // half a bit into the start bit, then whole bits
   assign rx_mid  = (rx_state == UART_START) ? (rx_cnt == CNT_W'(div / 2 - 1))
                                             : (rx_cnt == CNT_W'(div - 1));

   assign rsp = '{ready: rsp_ready, rdata: rsp_rdata};
   assign txd = tx_line;
   assign rts = !rx_valid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_ready <= 1'b0;
      end else if (soft_rst) begin
         rsp_ready <= 1'b0;
      end else begin
         rsp_ready <= acc;
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         rsp_rdata <= '0;
         case (reg_idx)
            UART_TXBUSY:  rsp_rdata[0] <= tx_busy;
            UART_RXDATA:  rsp_rdata[7:0] <= rx_byte;
            UART_RXVALID: rsp_rdata[0] <= rx_valid;
            default: ;
         endcase
      end
      if (tx_load) begin
         tx_byte <= req.wdata[7:0];
      end
      if (rx_state == UART_DATA && rx_mid) begin
         rx_shift <= {rx_in, rx_shift[7:1]};
      end
      if (rx_state == UART_STOP && rx_mid && rx_in) begin
         rx_byte <= rx_shift;
      end
   end

   // transmitter, start bit only with cts high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_state <= UART_IDLE;
         tx_pend  <= 1'b0;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         tx_line  <= 1'b1;
      end else if (soft_rst) begin
         tx_state <= UART_IDLE;
         tx_pend  <= 1'b0;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         tx_line  <= 1'b1;
      end else begin
         if (tx_load) begin
            tx_pend <= 1'b1;
         end
         tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
         case (tx_state)
            UART_IDLE: begin
               tx_cnt <= '0;
               if (tx_pend && cts) begin
                  tx_state <= UART_START;
                  tx_pend  <= 1'b0;
                  tx_line  <= 1'b0;
               end
            end
            UART_START: begin
               if (tx_tick) begin
                  tx_state <= UART_DATA;
                  tx_bit   <= '0;
                  tx_line  <= tx_byte[0];
               end
            end
            UART_DATA: begin
               if (tx_tick && tx_bit == 3'd7) begin
                  tx_state <= UART_STOP;
                  tx_line  <= 1'b1;
               end else if (tx_tick) begin
                  tx_bit  <= tx_bit + 3'd1;
                  tx_line <= tx_byte[tx_bit + 3'd1];
               end
            end
            default: begin
               if (tx_tick) begin
                  tx_state <= UART_IDLE;
               end
            end
         endcase
      end
   end

   // receiver
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_state <= UART_IDLE;
         rx_sync  <= 2'b11;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else if (soft_rst) begin
         rx_state <= UART_IDLE;
         rx_sync  <= 2'b11;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_sync <= {rx_sync[0], rxd};
         rx_cnt  <= rx_cnt + 1'b1;
         if (rx_rd) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            UART_IDLE: begin
               rx_cnt <= '0;
               if (!rx_in) begin
                  rx_state <= UART_START;
               end
            end
            UART_START: begin
               if (rx_mid) begin
                  rx_cnt   <= '0;
                  rx_bit   <= '0;
                  // glitch, back to idle
                  rx_state <= rx_in ? UART_IDLE : UART_DATA;
               end
            end
            UART_DATA: begin
               if (rx_mid) begin
                  rx_cnt <= '0;
                  rx_bit <= rx_bit + 3'd1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= UART_STOP;
                  end
               end
            end
            default: begin
               if (rx_mid) begin
                  rx_state <= UART_IDLE;
                  if (rx_in) begin
                     rx_valid <= 1'b1;
                  end
               end
            end
         endcase
      end
   end

endmodule

// File: source/rst_ctr.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module rst_ctr
   import soc_bus_pkg::*, soc_periph_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  dbus_req_t req,
   output dbus_rsp_t rsp,
   output logic      soft_rst,
   output logic      boot
);

   localparam int CNT_W = $clog2(`SOFT_RST_CYCLES + 1);

   rst_state_e         state;
   logic [CNT_W-1:0]   cnt;
   logic               rsp_ready;
   logic [`DATA_W-1:0] rsp_rdata;
   logic               acc;
   logic               pend;

   assign acc      = req.valid && !rsp_ready;
   assign soft_rst = state == RST_SOFT;
   assign rsp      = '{ready: rsp_ready, rdata: rsp_rdata};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= RST_RUN;
         cnt       <= '0;
         rsp_ready <= 1'b0;
         pend      <= 1'b0;
         boot      <= 1'b1;
      end else begin
         rsp_ready <= acc;
         // soft reset starts the cycle after ready
         pend      <= acc && (|req.wstrb) && req.wdata[0];
         case (state)
            RST_RUN: begin
               if (pend) begin
                  state <= RST_SOFT;
                  cnt   <= '0;
                  boot  <= 1'b0;
               end
            end
            default: begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_W'(`SOFT_RST_CYCLES - 1)) begin
                  state <= RST_RUN;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (acc) begin
         rsp_rdata <= {{(`DATA_W-1){1'b0}}, boot};
      end
   end

endmodule

// File: source/periph_intercon.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module periph_intercon
   import soc_bus_pkg::*, soc_periph_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  dbus_req_t req,
   output dbus_rsp_t rsp,
   output logic      uart_txd,
   input  logic      uart_rxd,
   output logic      uart_rts,
   input  logic      uart_cts,
   output logic      soft_rst,
   output logic      boot
);

   slave_sel_e sel;
   dbus_req_t  uart_req;
   dbus_req_t  rst_req;
   dbus_rsp_t  uart_rsp;
   dbus_rsp_t  rst_rsp;

   assign sel = slave_sel_e'(req.addr[`ADDR_W-2 -: `N_SLAVES_W]);

   // valid only to the addressed slave
   always_comb begin
      uart_req       = req;
      rst_req        = req;
      uart_req.valid = req.valid && (sel == SLV_UART);
      rst_req.valid  = req.valid && (sel == SLV_RST);
   end

   assign rsp = (sel == SLV_RST) ? rst_rsp : uart_rsp;

   uart #(
      .div (`UART_DIV)
   ) uart0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .soft_rst (soft_rst),
      .req      (uart_req),
      .rsp      (uart_rsp),
      .txd      (uart_txd),
      .rxd      (uart_rxd),
      .rts      (uart_rts),
      .cts      (uart_cts)
   );

   rst_ctr rst_ctr0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (rst_req),
      .rsp      (rst_rsp),
      .soft_rst (soft_rst),
      .boot     (boot)
   );

endmodule

// File: source/bus_select.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module bus_select
   import soc_bus_pkg::*;
(
   input  dbus_req_t req,
   output dbus_req_t mem_req,
   output dbus_req_t per_req,
   input  dbus_rsp_t mem_rsp,
   input  dbus_rsp_t per_rsp,
   output dbus_rsp_t rsp
);

   logic per_sel;

   // msb set means peripherals
   assign per_sel = req.addr[`ADDR_W-1];

   always_comb begin
      mem_req       = req;
      per_req       = req;
      mem_req.valid = req.valid && !per_sel;
      per_req.valid = req.valid && per_sel;
   end

   // request held until ready, so the current address picks the response
   assign rsp = per_sel ? per_rsp : mem_rsp;

endmodule

// File: source/system.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module system
   import soc_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  ibus_req_t ibus_req,
   output ibus_rsp_t ibus_rsp,
   input  dbus_req_t dbus_req,
   output dbus_rsp_t dbus_rsp,
   output logic      uart_txd,
   input  logic      uart_rxd,
   output logic      uart_rts,
   input  logic      uart_cts
);

   dbus_req_t mem_req;
   dbus_req_t per_req;
   dbus_rsp_t mem_rsp;
   dbus_rsp_t per_rsp;
   logic      soft_rst;
   logic      boot;

   bus_select bus_select0 (
      .req     (dbus_req),
      .mem_req (mem_req),
      .per_req (per_req),
      .mem_rsp (mem_rsp),
      .per_rsp (per_rsp),
      .rsp     (dbus_rsp)
   );

   int_mem int_mem0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .soft_rst (soft_rst),
      .boot     (boot),
      .ibus_req (ibus_req),
      .ibus_rsp (ibus_rsp),
      .req      (mem_req),
      .rsp      (mem_rsp)
   );

   periph_intercon periph0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (per_req),
      .rsp      (per_rsp),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd),
      .uart_rts (uart_rts),
      .uart_cts (uart_cts),
      .soft_rst (soft_rst),
      .boot     (boot)
   );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int period = 100
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // free running, first rising edge at half a period
   always #(period / 2) clk = ~clk;

endmodule

// File: test/tb_system.sv
`timescale 1ns/1ps
`include "soc_macros.svh"

module tb_system
   import soc_bus_pkg::*, soc_periph_pkg::*;
();

   localparam int N_WORDS      = 1 << (`MEM_ADDR_W - 2);
   localparam int FRAME_CYCLES = 10 * `UART_DIV;
   localparam int N_RANDOM     = 200;
   localparam int N_FETCH      = 64;
   localparam int N_SURVIVE    = 32;
   localparam int N_BYTES      = 8;
   localparam int EST_CYCLES   = 16 + 2 * N_WORDS + 2 * N_RANDOM + (N_FETCH + 1)
                                 + (6 + `SOFT_RST_CYCLES + 2 + N_FETCH + 1 + 2 * N_SURVIVE)
                                 + N_BYTES * 2 * FRAME_CYCLES + 5 * FRAME_CYCLES;
   localparam int TIMEOUT_CYCLES = 2 * EST_CYCLES;
   localparam logic [31:0] UART_BASE = 32'h8000_0000;
   localparam logic [31:0] RSTC_BASE = 32'hC000_0000;
   localparam logic [9:0]  BOOT_IDX  = `BOOT_BASE_W;

   logic        clk;
   logic        rst_n;
   ibus_req_t   ibus_req;
   ibus_rsp_t   ibus_rsp;
   dbus_req_t   dbus_req;
   dbus_rsp_t   dbus_rsp;
   logic        uart_txd;
   logic        uart_rxd;
   logic        uart_rts;
   logic        uart_cts;

   logic [31:0] seed;
   logic [31:0] model_mem [N_WORDS];
   logic        boot_m;
   int          cycle_cnt;

   tb_clk_gen #(.period(100)) clk_gen0 (.clk(clk));

   system DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .ibus_req (ibus_req),
      .ibus_rsp (ibus_rsp),
      .dbus_req (dbus_req),
      .dbus_rsp (dbus_rsp),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd),
      .uart_rts (uart_rts),
      .uart_cts (uart_cts)
   );

   // uart loopback
   assign uart_rxd = uart_txd;

   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("RESULT: FAIL");
         $fatal(1, "run stopped by cycle limit");
      end
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // depends on every bit of the word index
   function automatic logic [31:0] fill_word(input logic [9:0] idx);
      return ((32'(idx) + 32'd1) * 32'h9E37_79B1) ^ {idx, 22'h0};
   endfunction

   function automatic logic [31:0] word_addr(input logic [9:0] idx);
      return {20'h0, idx, 2'b00};
   endfunction

   function automatic logic [9:0] fetch_index(input logic [9:0] idx);
      return boot_m ? (idx | BOOT_IDX) : idx;
   endfunction

   function automatic logic [31:0] uart_addr(input uart_reg_e r);
      return UART_BASE | {27'h0, r, 2'b00};
   endfunction

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("RESULT: FAIL");
         $fatal(1, "stopping at first mismatch");
      end
   endtask

   task automatic fail_run(input string why);
      $display("error at %0t: %s", $time, why);
      $display("RESULT: FAIL");
      $fatal(1, "stopping on error");
   endtask

   // starts and ends on a falling edge with one idle cycle after ready
   task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata);
      int   waited;
      logic got;
      waited = 0;
      got    = 1'b0;
      dbus_req.valid = 1'b1;
      dbus_req.addr  = addr;
      dbus_req.wdata = wdata;
      dbus_req.wstrb = wstrb;
      while (!got) begin
         @(negedge clk);
         waited++;
         if (dbus_rsp.ready === 1'b1) begin
            got = 1'b1;
         end else if (waited >= 4) begin
            fail_run($sformatf("no ready within 4 cycles for address %h", addr));
         end
      end
      rdata = dbus_rsp.rdata;
      check("dbus_rsp.ready delay", waited, 1);
      dbus_req.valid = 1'b0;
      dbus_req.wstrb = 4'h0;
      @(negedge clk);
   endtask

   task automatic dbus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
      logic [31:0] unused;
      bus_access(addr, wdata, wstrb, unused);
   endtask

   task automatic dbus_read(input logic [31:0] addr, output logic [31:0] rdata);
      bus_access(addr, 32'h0, 4'h0, rdata);
   endtask

   task automatic run_random_mem();
      logic [31:0] r;
      logic [31:0] wd;
      logic [31:0] rd;
      logic [9:0]  idx;
      logic [3:0]  strb;
      for (int n = 0; n < N_RANDOM; n++) begin
         r   = next_rand();
         idx = r[25:16];
         if (r[31]) begin
            wd   = next_rand();
            strb = r[30:27];
            if (strb == 4'h0) begin
               strb = 4'hF;
            end
            dbus_write(word_addr(idx), wd, strb);
            for (int k = 0; k < 4; k++) begin
               if (strb[k]) begin
                  model_mem[idx][8*k +: 8] = wd[8*k +: 8];
               end
            end
         end else begin
            dbus_read(word_addr(idx), rd);
            check("dbus_rsp.rdata", rd, model_mem[idx]);
         end
      end
   endtask

   task automatic run_fetches();
      logic [31:0] r;
      logic        en;
      logic [9:0]  idx;
      for (int n = 0; n < N_FETCH; n++) begin
         r   = next_rand();
         en  = r[31] | r[30];
         idx = r[25:16];
         ibus_req.en   = en;
         ibus_req.addr = word_addr(idx);
         @(negedge clk);
         check("ibus_rsp.ready", ibus_rsp.ready, en);
         if (en) begin
            check("ibus_rsp.data", ibus_rsp.data, model_mem[fetch_index(idx)]);
         end
      end
      ibus_req.en = 1'b0;
      @(negedge clk);
      check("ibus_rsp.ready", ibus_rsp.ready, 1'b0);
   endtask

   task automatic wait_tx_idle();
      logic [31:0] v;
      int          polls;
      polls = 0;
      dbus_read(uart_addr(UART_TXBUSY), v);
      while (v !== 32'h0) begin
         polls++;
         if (polls > FRAME_CYCLES) begin
            fail_run("uart transmitter stayed busy");
         end
         dbus_read(uart_addr(UART_TXBUSY), v);
      end
   endtask

   task automatic receive_byte(input logic [7:0] expected);
      logic [31:0] v;
      int          polls;
      polls = 0;
      dbus_read(uart_addr(UART_RXVALID), v);
      while (v !== 32'h1) begin
         polls++;
         if (polls > FRAME_CYCLES) begin
            fail_run("uart byte not received within two frame times");
         end
         dbus_read(uart_addr(UART_RXVALID), v);
      end
      check("uart_rts", uart_rts, 1'b0);
      dbus_read(uart_addr(UART_RXDATA), v);
      check("uart RXDATA", v, {24'h0, expected});
      dbus_read(uart_addr(UART_RXVALID), v);
      check("uart RXVALID", v, 32'h0);
      check("uart_rts", uart_rts, 1'b1);
   endtask

   initial begin
      logic [31:0] r;
      logic [31:0] rd;
      logic [9:0]  idx;
      logic [7:0]  b;
      int          start;

      seed      = 32'h63768312;
      cycle_cnt = 0;
      boot_m    = 1'b1;
      rst_n     = 1'b0;
      ibus_req  = '0;
      dbus_req  = '0;
      uart_cts  = 1'b1;

      repeat (16) @(negedge clk);
      rst_n = 1'b1;

      check("dbus_rsp.ready", dbus_rsp.ready, 1'b0);
      check("ibus_rsp.ready", ibus_rsp.ready, 1'b0);
      check("uart_txd", uart_txd, 1'b1);
      check("uart_rts", uart_rts, 1'b1);

      // known contents everywhere before random traffic
      for (int i = 0; i < N_WORDS; i++) begin
         model_mem[i] = fill_word(10'(i));
         dbus_write(word_addr(10'(i)), model_mem[i], 4'hF);
      end

      run_random_mem();
      run_fetches();

      dbus_read(RSTC_BASE, rd);
      check("reset controller boot", rd, {31'h0, boot_m});
      dbus_write(RSTC_BASE, 32'h1, 4'hF);
      boot_m = 1'b0;
      repeat (`SOFT_RST_CYCLES + 2) @(negedge clk);
      dbus_read(RSTC_BASE, rd);
      check("reset controller boot", rd, {31'h0, boot_m});
      run_fetches();
      for (int n = 0; n < N_SURVIVE; n++) begin
         r   = next_rand();
         idx = r[25:16];
         dbus_read(word_addr(idx), rd);
         check("dbus_rsp.rdata", rd, model_mem[idx]);
      end

      for (int n = 0; n < N_BYTES; n++) begin
         r = next_rand();
         b = r[31:24];
         wait_tx_idle();
         dbus_write(uart_addr(UART_TXDATA), {24'h0, b}, 4'h1);
         receive_byte(b);
      end

      // byte must wait while cts is low
      uart_cts = 1'b0;
      wait_tx_idle();
      r = next_rand();
      b = r[31:24];
      dbus_write(uart_addr(UART_TXDATA), {24'h0, b}, 4'h1);
      start = cycle_cnt;
      while (cycle_cnt - start < 3 * FRAME_CYCLES) begin
         dbus_read(uart_addr(UART_TXBUSY), rd);
         check("uart TXBUSY", rd, 32'h1);
         check("uart_txd", uart_txd, 1'b1);
      end
      uart_cts = 1'b1;
      receive_byte(b);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: vlog.f
+incdir+source
source/soc_bus_pkg.sv
source/soc_periph_pkg.sv
source/int_mem.sv
source/uart.sv
source/rst_ctr.sv
source/periph_intercon.sv
source/bus_select.sv
source/system.sv
test/tb_clk_gen.sv
test/tb_system.sv
